/* include/bnn_conv_macros.svh */
`ifndef BNN_CONV_MACROS_SVH
`define BNN_CONV_MACROS_SVH

// Image geometry, single-bit pixels in raster order.
`define IMG_WIDTH 8
`define IMG_HEIGHT 6

// Square kernel, stride 1, no padding.
`define KERNEL_DIM 3

// Output channels, one neuron each.
`define OUT_CHANNELS 4

// Weight words per channel.
// Bit index is row * 3 + column, row 0 on top, column 0 on the left.
`define WEIGHT_0 9'b010_111_010
`define WEIGHT_1 9'b100_010_001
`define WEIGHT_2 9'b111_000_111
`define WEIGHT_3 9'b000_111_000

// Minimum match count for a 1 output, range 0 to 9.
`define THRESH_0 4'd5
`define THRESH_1 4'd6
`define THRESH_2 4'd4
`define THRESH_3 4'd9

`endif

/* src/bnn_conv_pkg.sv */
`default_nettype none

package bnn_conv_pkg;

    `include "bnn_conv_macros.svh"

    // One 3x3 window, seen two ways.
    // Row 0 is the top row, column 0 the left pixel.
    // So taps[8] is the newest pixel of the window.
    typedef union packed {
        // Flat view for the XNOR and the count.
        logic [`KERNEL_DIM*`KERNEL_DIM-1:0] taps;
        // Row view, rows[r][c] is taps[r*3+c].
        logic [`KERNEL_DIM-1:0][`KERNEL_DIM-1:0] rows;
    } window_t;

    // Match count, 0 up to the full kernel.
    typedef logic [$clog2(`KERNEL_DIM*`KERNEL_DIM+1)-1:0] match_cnt_t;

endpackage

`default_nettype wire

/* src/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_conv_macros.svh"

module line_buffer #(
    parameter int P_WIDTH = 8
) (
    input  wire                      clk,
    input  wire                      i_arst_n,

    input  wire                      i_we,
    input  wire                      i_data,

    output bnn_conv_pkg::window_t    o_window,
    output logic                     o_win_valid
);

    import bnn_conv_pkg::*;

    localparam int C_COL_W = $clog2(P_WIDTH);
    localparam int C_ROW_W = $clog2(`IMG_HEIGHT);
    localparam int C_EDGE  = `KERNEL_DIM - 1;

    // Previous row and the row before it.
    logic [P_WIDTH-1:0] line1_q;
    logic [P_WIDTH-1:0] line2_q;

    // Same column, one and two rows back.
    logic               up1_bit;
    logic               up2_bit;

    window_t            win_q;

    logic [C_COL_W-1:0] col_cnt;
    logic [C_ROW_W-1:0] row_cnt;
    logic               last_col;
    logic               last_row;
    logic               win_done;

    assign up1_bit = line1_q[P_WIDTH-1];
    assign up2_bit = line2_q[P_WIDTH-1];

    assign last_col = (col_cnt == C_COL_W'(P_WIDTH - 1));
    assign last_row = (row_cnt == C_ROW_W'(`IMG_HEIGHT - 1));

    // Window complete once both edges lie inside the image.
    assign win_done = (col_cnt >= C_COL_W'(C_EDGE)) && (row_cnt >= C_ROW_W'(C_EDGE));

    // Row storage.
    // The bit leaving line1 drops into line2.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            line1_q <= '0;
            line2_q <= '0;
        end else if (i_we) begin
            line1_q <= {line1_q[P_WIDTH-2:0], i_data};
            line2_q <= {line2_q[P_WIDTH-2:0], up1_bit};
        end
    end

    // Window shifts left by one column per pixel.
    // The new column enters at column 2.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            win_q.taps <= '0;
        end else if (i_we) begin
            win_q.rows[0] <= {up2_bit, win_q.rows[0][2:1]};
            win_q.rows[1] <= {up1_bit, win_q.rows[1][2:1]};
            win_q.rows[2] <= {i_data, win_q.rows[2][2:1]};
        end
    end

    // Raster position of the pixel being accepted.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_we) begin
            if (last_col) begin
                col_cnt <= '0;
                if (last_row) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // One cycle strobe after a completing pixel.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_we && win_done;
        end
    end

    assign o_window = win_q;

endmodule

`default_nettype wire

/* src/channel_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_neuron #(
    parameter logic [$bits(bnn_conv_pkg::window_t)-1:0] P_WEIGHT = '0,
    parameter bnn_conv_pkg::match_cnt_t                 P_THRESH = '0
) (
    input  wire                      clk,
    input  wire                      i_arst_n,

    input  wire                      i_valid,
    input  bnn_conv_pkg::window_t    i_window,

    output logic                     o_valid,
    output logic                     o_bit
);

    import bnn_conv_pkg::*;

    localparam int C_TAPS = $bits(window_t);

    logic [C_TAPS-1:0] match;
    match_cnt_t        match_cnt;
    logic              fire;

    // Number of set bits in a tap vector.
    function automatic match_cnt_t count_ones(input logic [C_TAPS-1:0] vec);
        match_cnt_t sum;
        sum = '0;
        for (int i = 0; i < C_TAPS; i++) begin
            sum = sum + match_cnt_t'(vec[i]);
        end
        return sum;
    endfunction

    // XNOR is the binary multiply.
    // A 1 marks a tap that agrees with its weight.
    assign match = ~(i_window.taps ^ P_WEIGHT);

    // Sum over the kernel.
    assign match_cnt = count_ones(match);

    // Sign by threshold.
    assign fire = (match_cnt >= P_THRESH);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Result bit holds between windows.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_bit <= 1'b0;
        end else if (i_valid) begin
            o_bit <= fire;
        end
    end

endmodule

`default_nettype wire

/* src/bnn_conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_conv_macros.svh"

module bnn_conv_top (
    input  wire                      clk,
    input  wire                      i_arst_n,

    input  wire                      i_we,
    input  wire                      i_data,

    output logic                     o_we,
    output logic [`OUT_CHANNELS-1:0] o_data
);

    import bnn_conv_pkg::*;

    // Per-channel constants, indexed by channel.
    localparam logic [$bits(window_t)-1:0] C_WEIGHTS [`OUT_CHANNELS] = '{
        `WEIGHT_0,
        `WEIGHT_1,
        `WEIGHT_2,
        `WEIGHT_3
    };

    localparam match_cnt_t C_THRESHS [`OUT_CHANNELS] = '{
        `THRESH_0,
        `THRESH_1,
        `THRESH_2,
        `THRESH_3
    };

    window_t                  window;
    logic                     win_valid;
    logic [`OUT_CHANNELS-1:0] ch_valid;

    line_buffer #(
        .P_WIDTH     (`IMG_WIDTH)
    ) u_line_buffer (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_we        (i_we),
        .i_data      (i_data),
        .o_window    (window),
        .o_win_valid (win_valid)
    );

    for (genvar ch = 0; ch < `OUT_CHANNELS; ch++) begin : g_channel
        channel_neuron #(
            .P_WEIGHT (C_WEIGHTS[ch]),
            .P_THRESH (C_THRESHS[ch])
        ) u_neuron (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .i_valid  (win_valid),
            .i_window (window),
            .o_valid  (ch_valid[ch]),
            .o_bit    (o_data[ch])
        );
    end

    // All channels share the same latency.
    assign o_we = ch_valid[0];

endmodule

`default_nettype wire

/* verif/tb_bnn_conv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_conv_macros.svh"

module tb_bnn_conv;

    localparam int CLK_PERIOD = 8;
    localparam int W = `IMG_WIDTH;
    localparam int H = `IMG_HEIGHT;
    localparam int NCH = `OUT_CHANNELS;
    localparam int FRAME_PIX = W * H;
    localparam int FRAME_RES = (W - 2) * (H - 2);
    // Six frames in all. Gapped pixels take up to four cycles each.
    localparam int TOTAL_PIX = 6 * FRAME_PIX;
    localparam int WATCHDOG_CYCLES = TOTAL_PIX * 4 + 36 + 200;

    localparam logic [8:0] WEIGHTS [NCH] = '{`WEIGHT_0, `WEIGHT_1, `WEIGHT_2, `WEIGHT_3};
    localparam int THRESHS [NCH] = '{`THRESH_0, `THRESH_1, `THRESH_2, `THRESH_3};

    logic           clk;
    logic           i_arst_n;
    logic           i_we;
    logic           i_data;
    logic           o_we;
    logic [NCH-1:0] o_data;

    logic [31:0]    lfsr_q;
    int             edge_cnt;
    int             err_cnt;
    int             check_cnt;
    int             test_cnt;
    int             strobe_cnt;

    logic           pix_q [$];
    logic [NCH-1:0] exp_q [$];
    logic [NCH-1:0] got_q [$];
    int             edge_q [$];

    bnn_conv_top dut (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_we     (i_we),
        .i_data   (i_data),
        .o_we     (o_we),
        .o_data   (o_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // Galois form with a right shift.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    // Expected bits for every window of every frame in the pixel queue.
    task automatic model_frames();
        int base;
        int cnt;
        logic [8:0] taps;
        logic [NCH-1:0] bits;
        for (int f = 0; f < pix_q.size() / FRAME_PIX; f++) begin
            base = f * FRAME_PIX;
            for (int r = 2; r < H; r++) begin
                for (int c = 2; c < W; c++) begin
                    for (int rr = 0; rr < 3; rr++) begin
                        for (int cc = 0; cc < 3; cc++) begin
                            taps[rr*3+cc] = pix_q[base + (r-2+rr)*W + (c-2+cc)];
                        end
                    end
                    for (int ch = 0; ch < NCH; ch++) begin
                        cnt = 0;
                        for (int i = 0; i < 9; i++) begin
                            if (taps[i] == WEIGHTS[ch][i]) cnt++;
                        end
                        bits[ch] = (cnt >= THRESHS[ch]);
                    end
                    exp_q.push_back(bits);
                end
            end
        end
    endtask

    task automatic load_random(input int frames);
        pix_q.delete();
        for (int i = 0; i < frames * FRAME_PIX; i++) begin
            pix_q.push_back(take_bit());
        end
    endtask

    // Streams the pixel queue and waits for all results.
    task automatic stream_and_check(input logic gapped);
        int idle;
        int pos;
        int frames;
        frames = pix_q.size() / FRAME_PIX;
        got_q.delete();
        strobe_cnt = 0;
        model_frames();
        for (int i = 0; i < pix_q.size(); i++) begin
            if (gapped) begin
                idle = {take_bit(), take_bit()};
                repeat (idle) begin
                    @(negedge clk);
                    i_we = 1'b0;
                end
            end
            @(negedge clk);
            i_we   = 1'b1;
            i_data = pix_q[i];
            pos    = i % FRAME_PIX;
            // Consumer takes o_we on the second edge after the accept edge.
            if (pos / W >= 2 && pos % W >= 2) edge_q.push_back(edge_cnt + 3);
        end
        @(negedge clk);
        i_we = 1'b0;
        while (edge_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        check_cnt++;
        assert (strobe_cnt == frames * FRAME_RES) else begin
            $display("FAILED at %0t: o_we count expected %0d got %0d",
                     $time, frames * FRAME_RES, strobe_cnt);
            err_cnt++;
        end
    endtask

    // Result monitor.
    always @(negedge clk) begin
        if (o_we) begin
            strobe_cnt++;
            if (edge_q.size() == 0) begin
                $display("ERROR at %0t: o_we strobe without a completed window", $time);
                err_cnt++;
            end else begin
                check_cnt += 2;
                assert (o_data == exp_q[0]) else begin
                    $display("FAILED at %0t: o_data expected %b got %b",
                             $time, exp_q[0], o_data);
                    err_cnt++;
                end
                assert (edge_cnt + 1 == edge_q[0]) else begin
                    $display("FAILED at %0t: o_we capture edge expected %0d got %0d",
                             $time, edge_q[0], edge_cnt + 1);
                    err_cnt++;
                end
                void'(exp_q.pop_front());
                void'(edge_q.pop_front());
                got_q.push_back(o_data);
            end
        end
    end

    task automatic check_idle_outputs();
        check_cnt += 2;
        assert (o_we == 1'b0) else begin
            $display("FAILED at %0t: o_we expected 0 got %b", $time, o_we);
            err_cnt++;
        end
        assert (o_data == '0) else begin
            $display("FAILED at %0t: o_data expected %b got %b", $time, {NCH{1'b0}}, o_data);
            err_cnt++;
        end
    endtask

    task automatic test_reset_state();
        int err_before;
        err_before = err_cnt;
        repeat (16) begin
            @(negedge clk);
            check_idle_outputs();
        end
        i_arst_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_idle_outputs();
        end
        test_cnt++;
        $display("Test reset_state done, errors %0d", err_cnt - err_before);
    endtask

    task automatic test_random_frame(input string name, input int frames, input logic gapped);
        int err_before;
        err_before = err_cnt;
        load_random(frames);
        stream_and_check(gapped);
        test_cnt++;
        $display("Test %s done, %0d results, errors %0d", name, strobe_cnt,
                 err_cnt - err_before);
    endtask

    // Windows on the 3x3 grid equal the tiled pattern exactly.
    task automatic check_aligned(input logic want);
        int idx;
        for (int r0 = 0; r0 <= H - 3; r0 += 3) begin
            for (int c0 = 0; c0 <= W - 3; c0 += 3) begin
                idx = r0 * (W - 2) + c0;
                check_cnt++;
                if (idx >= got_q.size()) begin
                    $display("ERROR at %0t: result %0d never arrived", $time, idx);
                    err_cnt++;
                end else begin
                    assert (got_q[idx][0] == want) else begin
                        $display("FAILED at %0t: o_data[0] expected %b got %b",
                                 $time, want, got_q[idx][0]);
                        err_cnt++;
                    end
                end
            end
        end
    endtask

    task automatic test_weight_patterns();
        int err_before;
        err_before = err_cnt;
        pix_q.delete();
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                pix_q.push_back(WEIGHTS[0][(r % 3) * 3 + (c % 3)]);
            end
        end
        stream_and_check(1'b0);
        check_aligned(1'b1);
        for (int i = 0; i < pix_q.size(); i++) begin
            pix_q[i] = ~pix_q[i];
        end
        stream_and_check(1'b0);
        check_aligned(THRESHS[0] == 0);
        test_cnt++;
        $display("Test weight_patterns done, errors %0d", err_cnt - err_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the DUT did not deliver all results in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        i_arst_n  = 1'b0;
        i_we      = 1'b0;
        i_data    = 1'b0;
        lfsr_q    = 32'hf0e7;
        edge_cnt  = 0;
        err_cnt   = 0;
        check_cnt = 0;
        test_cnt  = 0;
        test_reset_state();
        test_random_frame("random_frame", 1, 1'b0);
        test_weight_patterns();
        test_random_frame("gapped_strobes", 1, 1'b1);
        test_random_frame("back_to_back", 2, 1'b0);
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bnn_conv.f */
+incdir+include
src/bnn_conv_pkg.sv
src/line_buffer.sv
src/channel_neuron.sv
src/bnn_conv_top.sv
verif/tb_bnn_conv.sv

/* Bender.yml */
package:
  name: bnn_conv

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bnn_conv_pkg.sv
      - src/line_buffer.sv
      - src/channel_neuron.sv
      - src/bnn_conv_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_bnn_conv.sv
